//--- src.f
+incdir+include
source/mem_ctl_pkg.sv
source/gpio_reg.sv
source/byte_ram.sv
source/access_ctl.sv
source/test_mem_ctl.sv
verif/tb_test_mem_ctl.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_test_mem_ctl -f src.f -o tb_sim

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"

if echo "$sim_out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

//--- include/tb_vectors.svh
// Data-port test vectors of stores and reads with their expected read words
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row holds wr (1 for a store), address, write data, size as funct3
// and the expected read word
typedef struct packed {
    logic       wr;
    addr_t      addr;
    word_t      wdata;
    logic [2:0] size;
    word_t      exp;
} vec_t;

localparam int unsigned N_VEC = 26;

localparam vec_t VECTORS [N_VEC] = '{
    // Empty RAM reads as zero in both regions
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_1FFC, 32'h0000_0000, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_2000, 32'h0000_0000, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_3FFC, 32'h0000_0000, 3'd2, 32'h0000_0000},
    // Word store with byte and halfword stores over it
    '{1'b1, 32'h0000_2000, 32'h1122_3344, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_2000, 32'h0000_0000, 3'd2, 32'h1122_3344},
    '{1'b1, 32'h0000_2000, 32'hAABB_CCDD, 3'd0, 32'h0000_0000},
    '{1'b0, 32'h0000_2000, 32'h0000_0000, 3'd2, 32'h1122_33DD},
    '{1'b1, 32'h0000_2000, 32'h5566_EEFF, 3'd1, 32'h0000_0000},
    '{1'b0, 32'h0000_2000, 32'h0000_0000, 3'd2, 32'h1122_EEFF},
    // Byte store into the upper half of a word
    '{1'b1, 32'h0000_2004, 32'hCAFE_F00D, 3'd2, 32'h0000_0000},
    '{1'b1, 32'h0000_2006, 32'h0000_0077, 3'd0, 32'h0000_0000},
    '{1'b0, 32'h0000_2004, 32'h0000_0000, 3'd2, 32'hCA77_F00D},
    // Unused funct3 code stores one byte
    '{1'b1, 32'h0000_2008, 32'h0102_0304, 3'd2, 32'h0000_0000},
    '{1'b1, 32'h0000_2008, 32'hFFFF_FF99, 3'd5, 32'h0000_0000},
    '{1'b0, 32'h0000_2008, 32'h0000_0000, 3'd2, 32'h0102_0399},
    // Top word of the data region
    '{1'b1, 32'h0000_3FFC, 32'h89AB_CDEF, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_3FFC, 32'h0000_0000, 3'd2, 32'h89AB_CDEF},
    // Program region is read-only from the data port
    '{1'b1, 32'h0000_0100, 32'hDEAD_BEEF, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_0100, 32'h0000_0000, 3'd2, 32'h0000_0000},
    '{1'b1, 32'h0000_1FFC, 32'h0BAD_F00D, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_1FFC, 32'h0000_0000, 3'd2, 32'h0000_0000},
    // Unmapped addresses drop stores and read zero
    '{1'b1, 32'h0000_8000, 32'h1234_5678, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_8000, 32'h0000_0000, 3'd2, 32'h0000_0000},
    // Unmapped store whose upper lanes would wrap onto address zero
    '{1'b1, 32'hFFFF_FFFE, 32'h55AA_55AA, 3'd2, 32'h0000_0000},
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 3'd2, 32'h0000_0000}
};

`endif

//--- verif/tb_test_mem_ctl.sv
// Testbench for the test memory controller with data table, fetch and GPIO checks
`timescale 1ns/100ps

module tb_test_mem_ctl
    import mem_ctl_pkg::*;
();

    localparam int unsigned PROG_BYTES  = 8192;
    localparam int unsigned DATA_BYTES  = 8192;
    localparam int unsigned GPIO_WIDTH  = 5;
    localparam int unsigned INSTR_DELAY = 3;
    localparam int unsigned DATA_DELAY  = 2;

    localparam int unsigned N_FETCH     = 8;
    localparam int unsigned N_GPIO      = 4;
    localparam int unsigned STEP_CYCLES = INSTR_DELAY + DATA_DELAY + 4;
    localparam int unsigned DATA_BOUND  = INSTR_DELAY + DATA_DELAY + 1;
    localparam int unsigned GPIO_BOUND  = 2;
    localparam addr_t       FETCH_BASE  = 32'h0000_2100;
    localparam word_t       GPIO_MASK   = word_t'((1 << GPIO_WIDTH) - 1);
    localparam word_t       GPIO_VALS [2] = '{32'hFFFF_FFF5, 32'h1234_56AA};

    `include "tb_vectors.svh"

    localparam int unsigned TIMEOUT_CYCLES = (N_VEC + 2 * N_FETCH + N_GPIO) * STEP_CYCLES + 200;

    logic                  clk = 1'b0;
    logic                  rst_n;
    addr_t                 instr_addr;
    word_t                 instr_data;
    logic                  instr_ready;
    addr_t                 mem_addr;
    word_t                 mem_wdata;
    store_size_e           mem_size;
    logic                  mem_we;
    logic                  mem_re;
    word_t                 mem_rdata;
    logic                  mem_ready;
    logic [GPIO_WIDTH-1:0] gpio_out;

    int unsigned err_count;
    int unsigned check_count;
    int unsigned cycle_count;
    word_t       fetch_words [N_FETCH];

    test_mem_ctl #(
        .PROG_BYTES  (PROG_BYTES),
        .DATA_BYTES  (DATA_BYTES),
        .GPIO_WIDTH  (GPIO_WIDTH),
        .INSTR_DELAY (INSTR_DELAY),
        .DATA_DELAY  (DATA_DELAY)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_size    (mem_size),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .gpio_out    (gpio_out)
    );

    always #4 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string what, input int unsigned cycles,
                                 input int unsigned bound);
        check_count++;
        if (cycles > bound) begin
            err_count++;
            $display("%s took %0d cycles to answer, the limit is %0d", what, cycles, bound);
        end
    endtask

    // Starts on a falling edge and returns on the falling edge that sees mem_ready
    task automatic data_access(input logic wr, input addr_t addr, input word_t wdata,
                               input logic [2:0] size, output word_t rdata,
                               output int unsigned cycles);
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_size  = store_size_e'(size);
        mem_we    = wr;
        mem_re    = !wr;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mem_ready);
        rdata  = mem_rdata;
        mem_we = 1'b0;
        mem_re = 1'b0;
    endtask

    task automatic wait_fetch(output word_t data);
        do begin
            @(negedge clk);
        end while (!instr_ready);
        data = instr_data;
    endtask

    // ========================================
    // Test phases
    // ========================================

    task automatic apply_table();
        word_t       rdata;
        int unsigned cycles;
        for (int i = 0; i < N_VEC; i++) begin
            data_access(VECTORS[i].wr, VECTORS[i].addr, VECTORS[i].wdata, VECTORS[i].size,
                        rdata, cycles);
            check_latency($sformatf("Table row %0d", i), cycles, DATA_BOUND);
            if (!VECTORS[i].wr) begin
                compare_value($sformatf("mem_rdata row %0d", i), rdata, VECTORS[i].exp);
            end
            @(negedge clk);
        end
    endtask

    task automatic fetch_stored_words();
        word_t       rdata;
        word_t       got;
        int unsigned cycles;
        for (int i = 0; i < N_FETCH; i++) begin
            fetch_words[i] = $urandom;
            data_access(1'b1, FETCH_BASE + addr_t'(4 * i), fetch_words[i], 3'd2, rdata, cycles);
            check_latency($sformatf("Fetch store %0d", i), cycles, DATA_BOUND);
            @(negedge clk);
        end
        for (int i = 0; i < N_FETCH; i++) begin
            instr_addr = FETCH_BASE + addr_t'(4 * i);
            // First pulse may belong to a fetch of the old address
            wait_fetch(got);
            wait_fetch(got);
            compare_value($sformatf("instr_data fetch %0d", i), got, fetch_words[i]);
        end
        instr_addr = '0;
    endtask

    task automatic exercise_gpio();
        word_t       rdata;
        word_t       got;
        word_t       exp;
        int unsigned cycles;
        for (int j = 0; j < 2; j++) begin
            exp = GPIO_VALS[j] & GPIO_MASK;
            // Controller is idle right after a fetch completes
            wait_fetch(got);
            data_access(1'b1, GPIO_ADDR, GPIO_VALS[j], 3'd2, rdata, cycles);
            check_latency("GPIO write", cycles, GPIO_BOUND);
            compare_value("gpio_out", word_t'(gpio_out), exp);
            wait_fetch(got);
            data_access(1'b0, GPIO_ADDR, '0, 3'd2, rdata, cycles);
            check_latency("GPIO read", cycles, GPIO_BOUND);
            compare_value("mem_rdata gpio", rdata, exp);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        void'($urandom(32'h81bc5d21));
        err_count   = 0;
        check_count = 0;
        rst_n       = 1'b0;
        instr_addr  = '0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_size    = size_word;
        mem_we      = 1'b0;
        mem_re      = 1'b0;

        repeat (16) @(negedge clk);
        compare_value("mem_ready", word_t'(mem_ready), '0);
        compare_value("instr_ready", word_t'(instr_ready), '0);
        compare_value("gpio_out", word_t'(gpio_out), '0);
        compare_value("mem_rdata", mem_rdata, '0);
        compare_value("instr_data", instr_data, '0);
        rst_n = 1'b1;
        @(negedge clk);

        apply_table();
        fetch_stored_words();
        exercise_gpio();

        $display("Check count: %0d, error count: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Run limit in clock cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- source/test_mem_ctl.sv
// Test memory controller top level joining the access controller, byte RAM and GPIO register
`timescale 1ns/100ps

module test_mem_ctl
    import mem_ctl_pkg::*;
#(
    parameter int unsigned PROG_BYTES  = 8192,
    parameter int unsigned DATA_BYTES  = 8192,
    parameter int unsigned GPIO_WIDTH  = 5,
    parameter int unsigned INSTR_DELAY = 3,
    parameter int unsigned DATA_DELAY  = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Fetch port
    input  addr_t                 instr_addr,
    output word_t                 instr_data,
    output logic                  instr_ready,
    // Data port
    input  addr_t                 mem_addr,
    input  word_t                 mem_wdata,
    input  store_size_e           mem_size,
    input  logic                  mem_we,
    input  logic                  mem_re,
    output word_t                 mem_rdata,
    output logic                  mem_ready,
    // GPIO pins
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    ram_cmd_t              ram_cmd;
    addr_t                 ram_fetch_addr;
    word_t                 ram_data_rdata;
    word_t                 ram_fetch_rdata;
    logic                  gpio_we;
    logic [GPIO_WIDTH-1:0] gpio_wdata;
    logic [GPIO_WIDTH-1:0] gpio_rdata;

    access_ctl #(
        .PROG_BYTES  (PROG_BYTES),
        .DATA_BYTES  (DATA_BYTES),
        .GPIO_WIDTH  (GPIO_WIDTH),
        .INSTR_DELAY (INSTR_DELAY),
        .DATA_DELAY  (DATA_DELAY)
    ) u_access_ctl (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_addr      (instr_addr),
        .instr_data      (instr_data),
        .instr_ready     (instr_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_size        (mem_size),
        .mem_we          (mem_we),
        .mem_re          (mem_re),
        .mem_rdata       (mem_rdata),
        .mem_ready       (mem_ready),
        .ram_cmd         (ram_cmd),
        .ram_fetch_addr  (ram_fetch_addr),
        .ram_data_rdata  (ram_data_rdata),
        .ram_fetch_rdata (ram_fetch_rdata),
        .gpio_we         (gpio_we),
        .gpio_wdata      (gpio_wdata),
        .gpio_rdata      (gpio_rdata)
    );

    byte_ram #(
        .PROG_BYTES (PROG_BYTES),
        .DATA_BYTES (DATA_BYTES)
    ) u_byte_ram (
        .clk         (clk),
        .cmd         (ram_cmd),
        .fetch_addr  (ram_fetch_addr),
        .data_rdata  (ram_data_rdata),
        .fetch_rdata (ram_fetch_rdata)
    );

    gpio_reg #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_gpio_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (gpio_we),
        .wdata    (gpio_wdata),
        .rdata    (gpio_rdata),
        .gpio_out (gpio_out)
    );

endmodule

//--- source/access_ctl.sv
// Access controller with data-over-fetch arbitration, delay counting and address decode
`timescale 1ns/100ps

module access_ctl
    import mem_ctl_pkg::*;
#(
    parameter int unsigned PROG_BYTES  = 8192,
    parameter int unsigned DATA_BYTES  = 8192,
    parameter int unsigned GPIO_WIDTH  = 5,
    parameter int unsigned INSTR_DELAY = 3,
    parameter int unsigned DATA_DELAY  = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Fetch port
    input  addr_t                 instr_addr,
    output word_t                 instr_data,
    output logic                  instr_ready,
    // Data port
    input  addr_t                 mem_addr,
    input  word_t                 mem_wdata,
    input  store_size_e           mem_size,
    input  logic                  mem_we,
    input  logic                  mem_re,
    output word_t                 mem_rdata,
    output logic                  mem_ready,
    // Byte array
    output ram_cmd_t              ram_cmd,
    output addr_t                 ram_fetch_addr,
    input  word_t                 ram_data_rdata,
    input  word_t                 ram_fetch_rdata,
    // GPIO register
    output logic                  gpio_we,
    output logic [GPIO_WIDTH-1:0] gpio_wdata,
    input  logic [GPIO_WIDTH-1:0] gpio_rdata
);

    localparam int unsigned MAX_DELAY = (INSTR_DELAY > DATA_DELAY) ? INSTR_DELAY : DATA_DELAY;
    localparam int unsigned CNT_W     = (MAX_DELAY > 1) ? $clog2(MAX_DELAY) : 1;

    localparam logic [CNT_W-1:0] INSTR_CNT = CNT_W'(INSTR_DELAY - 1);
    localparam logic [CNT_W-1:0] DATA_CNT  = CNT_W'(DATA_DELAY - 1);

    localparam addr_t DATA_BASE = addr_t'(PROG_BYTES);
    localparam addr_t RAM_END   = addr_t'(PROG_BYTES + DATA_BYTES);

    ctl_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic             cur_is_instr;
    logic             cur_we;
    addr_t            cur_addr;
    word_t            cur_wdata;
    store_size_e      cur_size;

    logic  data_req;
    logic  gpio_hit;
    logic  in_ram;
    logic  data_wr;
    logic  done;
    logic  store_go;
    word_t gpio_ext;

    // ========================================
    // Request and address decode
    // ========================================

    assign data_req = mem_we || mem_re;

    // GPIO is decided on the live address at the start edge
    assign gpio_hit = (mem_addr == GPIO_ADDR);

    // RAM regions are decided on the captured address
    assign in_ram  = (cur_addr < RAM_END);
    assign data_wr = in_ram && (cur_addr >= DATA_BASE);

    assign done     = (state == st_active) && (cnt == '0);
    assign store_go = done && !cur_is_instr && cur_we && data_wr;

    assign gpio_we    = (state == st_idle) && data_req && gpio_hit && mem_we;
    assign gpio_wdata = mem_wdata[GPIO_WIDTH-1:0];
    assign gpio_ext   = word_t'(gpio_rdata);

    // Store commits on the same edge that raises mem_ready
    always_comb begin
        ram_cmd.addr  = cur_addr;
        ram_cmd.wdata = cur_wdata;
        ram_cmd.size  = cur_size;
        ram_cmd.we    = store_go;
    end

    assign ram_fetch_addr = cur_addr;

    // ========================================
    // Captured access
    // ========================================

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            if (data_req) begin
                cur_addr  <= mem_addr;
                cur_wdata <= mem_wdata;
                cur_size  <= mem_size;
            end else begin
                cur_addr <= instr_addr;
            end
        end
    end

    // ========================================
    // Controller FSM
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            cnt          <= '0;
            cur_is_instr <= 1'b0;
            cur_we       <= 1'b0;
            instr_ready  <= 1'b0;
            mem_ready    <= 1'b0;
            instr_data   <= '0;
            mem_rdata    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    instr_ready <= 1'b0;
                    mem_ready   <= 1'b0;
                    if (data_req && gpio_hit) begin
                        // Immediate answer while the controller stays idle
                        if (!mem_we) begin
                            mem_rdata <= gpio_ext;
                        end
                        mem_ready <= 1'b1;
                    end else if (data_req) begin
                        state        <= st_active;
                        cnt          <= DATA_CNT;
                        cur_is_instr <= 1'b0;
                        cur_we       <= mem_we;
                    end else begin
                        // Fetch runs whenever the data port is quiet
                        state        <= st_active;
                        cnt          <= INSTR_CNT;
                        cur_is_instr <= 1'b1;
                        cur_we       <= 1'b0;
                    end
                end
                st_active: begin
                    if (done) begin
                        state <= st_idle;
                        if (cur_is_instr) begin
                            instr_data  <= in_ram ? ram_fetch_rdata : '0;
                            instr_ready <= 1'b1;
                        end else begin
                            // Unmapped reads return zero
                            if (!cur_we) begin
                                mem_rdata <= in_ram ? ram_data_rdata : '0;
                            end
                            mem_ready <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- source/byte_ram.sv
// Byte-addressed RAM with lane-selected stores and two little-endian read ports
`timescale 1ns/100ps

module byte_ram
    import mem_ctl_pkg::*;
#(
    parameter int unsigned PROG_BYTES = 8192,
    parameter int unsigned DATA_BYTES = 8192
) (
    input  logic     clk,
    input  ram_cmd_t cmd,
    input  addr_t    fetch_addr,
    output word_t    data_rdata,
    output word_t    fetch_rdata
);

    localparam int unsigned TOTAL_BYTES = PROG_BYTES + DATA_BYTES;

    logic [7:0] mem [TOTAL_BYTES];
    logic [3:0] lane_en;

    // Bytes past the top of the array read as zero
    function automatic word_t read_word(input addr_t base);
        word_t w;
        addr_t a;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            a = base + addr_t'(i);
            if (a < addr_t'(TOTAL_BYTES)) begin
                w[8*i +: 8] = mem[a];
            end
        end
        return w;
    endfunction

    initial begin
        for (int i = 0; i < TOTAL_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    // Halfword and word widen the lanes and unused funct3 codes store one byte
    always_comb begin
        case (cmd.size)
            size_half: lane_en = 4'b0011;
            size_word: lane_en = 4'b1111;
            default:   lane_en = 4'b0001;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmd.we) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) begin
                    mem[cmd.addr + addr_t'(i)] <= cmd.wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        data_rdata  = read_word(cmd.addr);
        fetch_rdata = read_word(fetch_addr);
    end

endmodule

//--- source/gpio_reg.sv
// GPIO output register with write port and read-back
`timescale 1ns/100ps

module gpio_reg #(
    parameter int unsigned GPIO_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  logic [GPIO_WIDTH-1:0] wdata,
    output logic [GPIO_WIDTH-1:0] rdata,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    logic [GPIO_WIDTH-1:0] gpio_q;

    // Pins come up low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_q <= '0;
        end else if (we) begin
            gpio_q <= wdata;
        end
    end

    // Same register feeds the pins and the read-back path
    assign gpio_out = gpio_q;
    assign rdata    = gpio_q;

endmodule

//--- source/mem_ctl_pkg.sv
// Memory controller package with shared address, data and command types

package mem_ctl_pkg;

    // ========================================
    // Basic widths
    // ========================================

    // Byte address as seen by the core
    typedef logic [31:0] addr_t;

    // One data word stored little-endian in memory
    typedef logic [31:0] word_t;

    // Store size carried as the funct3 of the store instruction
    typedef enum logic [2:0] {
        size_byte = 3'd0,
        size_half = 3'd1,
        size_word = 3'd2
    } store_size_e;

    // ========================================
    // Controller types
    // ========================================

    // Access controller states
    typedef enum logic {
        st_idle,
        st_active
    } ctl_state_e;

    // Command from the access controller to the byte array
    typedef struct packed {
        addr_t       addr;
        word_t       wdata;
        store_size_e size;
        logic        we;    // one-cycle store strobe
    } ram_cmd_t;

    // ========================================
    // Address map
    // ========================================

    // GPIO output register that answers without delay
    localparam addr_t GPIO_ADDR = 32'h4000_1000;

endpackage
